//--- common/uart_pkg.sv
package uart_pkg;

        // serial byte and bus widths.
        typedef logic [7:0]  uart_byte_t;
        typedef logic [3:0]  axil_addr_t;
        typedef logic [31:0] axil_word_t;

        // register byte offsets.
        localparam axil_addr_t reg_txdata = 4'h0;
        localparam axil_addr_t reg_rxdata = 4'h4;
        localparam axil_addr_t reg_status = 4'h8;

        // status word bit positions.
        localparam int st_rx_valid  = 0;
        localparam int st_tx_busy   = 1;
        localparam int st_overrun   = 2;
        localparam int st_frame_err = 3;

        typedef logic [1:0] axil_resp_t;
        localparam axil_resp_t okay   = 2'b00;
        localparam axil_resp_t slverr = 2'b10;

        typedef struct packed {
                logic       awvalid;
                axil_addr_t awaddr;
                logic       wvalid;
                axil_word_t wdata;
                logic       bready;
                logic       arvalid;
                axil_addr_t araddr;
                logic       rready;
        } axil_req_t;

        typedef struct packed {
                logic       awready;
                logic       wready;
                logic       bvalid;
                axil_resp_t bresp;
                logic       arready;
                logic       rvalid;
                axil_word_t rdata;
                axil_resp_t rresp;
        } axil_rsp_t;

        // done is high for one cycle per received frame.
        typedef struct packed {
                logic       done;
                uart_byte_t data;
                logic       frame_err;
        } rx_event_t;

endpackage

//--- rtl/uart_rx.sv
`timescale 1ns/1ns

module uart_rx #(
        parameter int clks_per_bit = 16
) (
        input  logic                clk,
        input  logic                arst_n,
        input  logic                rx,
        output uart_pkg::rx_event_t rx_evt
);
        import uart_pkg::*;

        localparam int cnt_w = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;

        typedef logic [cnt_w-1:0] cnt_t;

        localparam cnt_t full_bit = cnt_t'(clks_per_bit - 1);
        localparam cnt_t half_bit = cnt_t'(clks_per_bit / 2 - 1);

        typedef enum logic [1:0] {
                s_idle,
                s_start,
                s_data,
                s_stop
        } rx_state_t;

        rx_state_t  state;
        cnt_t       cnt;
        logic [2:0] bit_cnt;
        logic       rx_meta;
        logic       rx_sync;
        logic       rx_prev;
        logic       done_q;
        logic       ferr_q;
        uart_byte_t shift_q;

        // two-stage synchroniser plus one delay for edge detect.
        always_ff @(posedge clk or negedge arst_n)
        begin
                if (!arst_n)
                begin
                        rx_meta <= 1'b1;
                        rx_sync <= 1'b1;
                        rx_prev <= 1'b1;
                end
                else
                begin
                        rx_meta <= rx;
                        rx_sync <= rx_meta;
                        rx_prev <= rx_sync;
                end
        end

        always_ff @(posedge clk or negedge arst_n)
        begin
                if (!arst_n)
                begin
                        state   <= s_idle;
                        cnt     <= '0;
                        bit_cnt <= '0;
                        done_q  <= 1'b0;
                end
                else
                begin
                        done_q <= 1'b0;
                        case (state)
                        s_idle:
                                if (rx_prev && !rx_sync)
                                begin
                                        state <= s_start;
                                        cnt   <= '0;
                                end
                        s_start:
                                if (cnt == half_bit)
                                begin
                                        cnt     <= '0;
                                        bit_cnt <= '0;
                                        // high at the centre means a glitch.
                                        state   <= rx_sync ? s_idle : s_data;
                                end
                                else
                                        cnt <= cnt + cnt_t'(1);
                        s_data:
                                if (cnt == full_bit)
                                begin
                                        cnt     <= '0;
                                        bit_cnt <= bit_cnt + 3'd1;
                                        if (bit_cnt == 3'd7)
                                                state <= s_stop;
                                end
                                else
                                        cnt <= cnt + cnt_t'(1);
                        s_stop:
                                if (cnt == full_bit)
                                begin
                                        cnt    <= '0;
                                        done_q <= 1'b1;
                                        state  <= s_idle;
                                end
                                else
                                        cnt <= cnt + cnt_t'(1);
                        default:
                                state <= s_idle;
                        endcase
                end
        end

        // lsb arrives first.
        always_ff @(posedge clk)
        begin
                if (state == s_data && cnt == full_bit)
                        shift_q <= {rx_sync, shift_q[7:1]};
                if (state == s_stop && cnt == full_bit)
                        ferr_q <= !rx_sync;
        end

        always_comb
        begin
                rx_evt.done      = done_q;
                rx_evt.data      = shift_q;
                rx_evt.frame_err = ferr_q;
        end

endmodule

//--- rtl/uart_tx.sv
`timescale 1ns/1ns

module uart_tx #(
        parameter int clks_per_bit = 16
) (
        input  logic                 clk,
        input  logic                 arst_n,
        input  logic                 tx_start,
        input  uart_pkg::uart_byte_t tx_data,
        output logic                 tx,
        output logic                 tx_busy
);

        localparam int cnt_w = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;

        typedef logic [cnt_w-1:0] cnt_t;

        localparam cnt_t full_bit = cnt_t'(clks_per_bit - 1);

        typedef enum logic [1:0] {
                s_idle,
                s_start,
                s_data,
                s_stop
        } tx_state_t;

        tx_state_t  state;
        cnt_t       cnt;
        logic [2:0] bit_cnt;
        logic [9:0] frame_q;

        // bit 0 of the frame is always on the line.
        assign tx = frame_q[0];

        always_ff @(posedge clk or negedge arst_n)
        begin
                if (!arst_n)
                begin
                        state   <= s_idle;
                        cnt     <= '0;
                        bit_cnt <= '0;
                        frame_q <= '1;
                        tx_busy <= 1'b0;
                end
                else
                begin
                        case (state)
                        s_idle:
                                if (tx_start)
                                begin
                                        frame_q <= {1'b1, tx_data, 1'b0};
                                        cnt     <= '0;
                                        tx_busy <= 1'b1;
                                        state   <= s_start;
                                end
                        s_start:
                                if (cnt == full_bit)
                                begin
                                        cnt     <= '0;
                                        bit_cnt <= '0;
                                        frame_q <= {1'b1, frame_q[9:1]};
                                        state   <= s_data;
                                end
                                else
                                        cnt <= cnt + cnt_t'(1);
                        s_data:
                                if (cnt == full_bit)
                                begin
                                        cnt     <= '0;
                                        bit_cnt <= bit_cnt + 3'd1;
                                        frame_q <= {1'b1, frame_q[9:1]};
                                        if (bit_cnt == 3'd7)
                                                state <= s_stop;
                                end
                                else
                                        cnt <= cnt + cnt_t'(1);
                        s_stop:
                                if (cnt == full_bit)
                                begin
                                        cnt     <= '0;
                                        frame_q <= '1;
                                        tx_busy <= 1'b0;
                                        state   <= s_idle;
                                end
                                else
                                        cnt <= cnt + cnt_t'(1);
                        default:
                                state <= s_idle;
                        endcase
                end
        end

endmodule

//--- rtl/uart_regs.sv
`timescale 1ns/1ns

module uart_regs (
        input  logic                 clk,
        input  logic                 arst_n,
        input  uart_pkg::axil_req_t  axi_req,
        output uart_pkg::axil_rsp_t  axi_rsp,
        input  uart_pkg::rx_event_t  rx_evt,
        output logic                 tx_start,
        output uart_pkg::uart_byte_t tx_data,
        input  logic                 tx_busy
);
        import uart_pkg::*;

        logic       wr_accept;
        logic       rd_accept;
        logic       wr_ok;
        logic       rd_rxdata;
        logic       rd_status;
        logic       bvalid_q;
        logic       rvalid_q;
        axil_resp_t bresp_q;
        axil_resp_t rresp_q;
        axil_word_t rdata_q;
        axil_word_t rd_word;
        axil_resp_t rd_resp;
        axil_word_t status_word;
        uart_byte_t rx_byte;
        logic       rx_valid;
        logic       overrun;
        logic       frame_err;

        // a pending response blocks the next request.
        assign wr_accept = axi_req.awvalid && axi_req.wvalid && !bvalid_q;
        assign rd_accept = axi_req.arvalid && !rvalid_q;

        // only txdata is writable, and only while idle.
        assign wr_ok     = (axi_req.awaddr == reg_txdata) && !tx_busy;
        assign rd_rxdata = rd_accept && (axi_req.araddr == reg_rxdata);
        assign rd_status = rd_accept && (axi_req.araddr == reg_status);

        always_comb
        begin
                status_word               = '0;
                status_word[st_rx_valid]  = rx_valid;
                status_word[st_tx_busy]   = tx_busy;
                status_word[st_overrun]   = overrun;
                status_word[st_frame_err] = frame_err;
        end

        always_comb
        begin
                rd_word = '0;
                rd_resp = slverr;
                case (axi_req.araddr)
                reg_rxdata:
                begin
                        rd_word = axil_word_t'(rx_byte);
                        rd_resp = okay;
                end
                reg_status:
                begin
                        rd_word = status_word;
                        rd_resp = okay;
                end
                default:
                        rd_resp = slverr;
                endcase
        end

        always_comb
        begin
                axi_rsp.awready = wr_accept;
                axi_rsp.wready  = wr_accept;
                axi_rsp.bvalid  = bvalid_q;
                axi_rsp.bresp   = bresp_q;
                axi_rsp.arready = rd_accept;
                axi_rsp.rvalid  = rvalid_q;
                axi_rsp.rdata   = rdata_q;
                axi_rsp.rresp   = rresp_q;
        end

        always_ff @(posedge clk or negedge arst_n)
        begin
                if (!arst_n)
                begin
                        bvalid_q <= 1'b0;
                        rvalid_q <= 1'b0;
                        tx_start <= 1'b0;
                end
                else
                begin
                        tx_start <= wr_accept && wr_ok;
                        if (wr_accept)
                                bvalid_q <= 1'b1;
                        else if (axi_req.bready)
                                bvalid_q <= 1'b0;
                        if (rd_accept)
                                rvalid_q <= 1'b1;
                        else if (axi_req.rready)
                                rvalid_q <= 1'b0;
                end
        end

        always_ff @(posedge clk)
        begin
                if (wr_accept)
                        bresp_q <= wr_ok ? okay : slverr;
                if (wr_accept && wr_ok)
                        tx_data <= axi_req.wdata[7:0];
                if (rd_accept)
                begin
                        rdata_q <= rd_word;
                        rresp_q <= rd_resp;
                end
                if (rx_evt.done)
                        rx_byte <= rx_evt.data;
        end

        // a new frame wins over a clearing read in the same cycle.
        always_ff @(posedge clk or negedge arst_n)
        begin
                if (!arst_n)
                begin
                        rx_valid  <= 1'b0;
                        overrun   <= 1'b0;
                        frame_err <= 1'b0;
                end
                else
                begin
                        if (rd_rxdata)
                                rx_valid <= 1'b0;
                        if (rd_status)
                        begin
                                overrun   <= 1'b0;
                                frame_err <= 1'b0;
                        end
                        if (rx_evt.done)
                        begin
                                rx_valid <= 1'b1;
                                // old byte is still unread.
                                if (rx_valid && !rd_rxdata)
                                        overrun <= 1'b1;
                                if (rx_evt.frame_err)
                                        frame_err <= 1'b1;
                        end
                end
        end

endmodule

//--- rtl/uart_top.sv
`timescale 1ns/1ns

module uart_top #(
        parameter int clks_per_bit = 16
) (
        input  logic                clk,
        input  logic                arst_n,
        input  uart_pkg::axil_req_t axi_req,
        output uart_pkg::axil_rsp_t axi_rsp,
        input  logic                rx,
        output logic                tx
);
        import uart_pkg::*;

        rx_event_t  rx_evt;
        logic       tx_start;
        uart_byte_t tx_data;
        logic       tx_busy;

        uart_rx #(
                .clks_per_bit (clks_per_bit)
        ) u_rx (
                .clk    (clk),
                .arst_n (arst_n),
                .rx     (rx),
                .rx_evt (rx_evt)
        );

        uart_tx #(
                .clks_per_bit (clks_per_bit)
        ) u_tx (
                .clk      (clk),
                .arst_n   (arst_n),
                .tx_start (tx_start),
                .tx_data  (tx_data),
                .tx       (tx),
                .tx_busy  (tx_busy)
        );

        // bus side, joins both directions.
        uart_regs u_regs (
                .clk      (clk),
                .arst_n   (arst_n),
                .axi_req  (axi_req),
                .axi_rsp  (axi_rsp),
                .rx_evt   (rx_evt),
                .tx_start (tx_start),
                .tx_data  (tx_data),
                .tx_busy  (tx_busy)
        );

endmodule

//--- verification/uart_tb.sv
`timescale 1ns/1ns

module uart_tb;
        import uart_pkg::*;

        localparam int clks_per_bit = 8;
        localparam int wait_limit   = 40 * clks_per_bit;
        localparam int idle_limit   = 200000;

        logic       clk;
        logic       arst_n;
        logic       rx;
        logic       tx;
        axil_req_t  axi_req;
        axil_rsp_t  axi_rsp;
        int         errors = 0;
        int         timeouts = 0;
        int         frames_checked = 0;
        int         seed = 32'hbc8ac8fb;
        logic       aborted = 1'b0;
        logic       finished = 1'b0;
        uart_byte_t exp_q[$];

        uart_top #(
                .clks_per_bit (clks_per_bit)
        ) uut (
                .clk     (clk),
                .arst_n  (arst_n),
                .axi_req (axi_req),
                .axi_rsp (axi_rsp),
                .rx      (rx),
                .tx      (tx)
        );

        initial
        begin
                clk = 1'b0;
                forever #5 clk = ~clk;
        end

        // start bit, data lsb first, stop bit.
        function automatic logic [9:0] frame_of(uart_byte_t b);
                logic [9:0] f;
                int         i;
                f[0] = 1'b0;
                for (i = 0; i < 8; i++)
                        f[i + 1] = b[i];
                f[9] = 1'b1;
                return f;
        endfunction

        function automatic axil_word_t status_of(logic rxv, logic busy, logic ovr, logic ferr);
                axil_word_t w;
                w               = '0;
                w[st_rx_valid]  = rxv;
                w[st_tx_busy]   = busy;
                w[st_overrun]   = ovr;
                w[st_frame_err] = ferr;
                return w;
        endfunction

        task automatic report_mismatch(string what, logic [31:0] exp, logic [31:0] got);
                errors++;
                $display("ERROR at %0t ns: %s expected %h got %h", $time, what, exp, got);
        endtask

        // only the first expired wait is reported, later waits fall through.
        task automatic report_timeout(string what);
                if (!aborted)
                begin
                        timeouts++;
                        $display("timeout at %0t ns while waiting for %s", $time, what);
                end
                aborted = 1'b1;
        endtask

        task automatic axil_write(axil_addr_t addr, axil_word_t data, output axil_resp_t resp);
                int n;
                @(posedge clk);
                axi_req.awvalid <= 1'b1;
                axi_req.awaddr  <= addr;
                axi_req.wvalid  <= 1'b1;
                axi_req.wdata   <= data;
                axi_req.bready  <= 1'b1;
                n = 0;
                @(negedge clk);
                while (!(axi_rsp.awready && axi_rsp.wready) && !aborted && n < wait_limit)
                begin
                        @(negedge clk);
                        n++;
                end
                if (!(axi_rsp.awready && axi_rsp.wready))
                        report_timeout("the write address and data handshake");
                @(posedge clk);
                axi_req.awvalid <= 1'b0;
                axi_req.wvalid  <= 1'b0;
                n = 0;
                @(negedge clk);
                while (!axi_rsp.bvalid && !aborted && n < wait_limit)
                begin
                        @(negedge clk);
                        n++;
                end
                if (!axi_rsp.bvalid)
                        report_timeout("the write response");
                resp = axi_rsp.bresp;
                @(posedge clk);
                axi_req.bready <= 1'b0;
        endtask

        task automatic axil_read(axil_addr_t addr, output axil_word_t data,
                                 output axil_resp_t resp);
                int n;
                @(posedge clk);
                axi_req.arvalid <= 1'b1;
                axi_req.araddr  <= addr;
                axi_req.rready  <= 1'b1;
                n = 0;
                @(negedge clk);
                while (!axi_rsp.arready && !aborted && n < wait_limit)
                begin
                        @(negedge clk);
                        n++;
                end
                if (!axi_rsp.arready)
                        report_timeout("the read address handshake");
                @(posedge clk);
                axi_req.arvalid <= 1'b0;
                n = 0;
                @(negedge clk);
                while (!axi_rsp.rvalid && !aborted && n < wait_limit)
                begin
                        @(negedge clk);
                        n++;
                end
                if (!axi_rsp.rvalid)
                        report_timeout("the read data");
                data = axi_rsp.rdata;
                resp = axi_rsp.rresp;
                @(posedge clk);
                axi_req.rready <= 1'b0;
        endtask

        task automatic poll_status(int pos, logic level, output axil_word_t word);
                axil_resp_t resp;
                int         n;
                n = 0;
                axil_read(reg_status, word, resp);
                while (word[pos] !== level && !aborted && n < wait_limit)
                begin
                        axil_read(reg_status, word, resp);
                        n++;
                end
                if (word[pos] !== level)
                        report_timeout("a status flag to change");
        endtask

        task automatic wait_frames(int count);
                int n;
                n = 0;
                while (frames_checked < count && !aborted && n < wait_limit)
                begin
                        @(posedge clk);
                        n++;
                end
                if (frames_checked < count)
                        report_timeout("the tx frame monitor");
        endtask

        task automatic send_frame(uart_byte_t b, logic stop);
                logic [9:0] bits;
                int         i;
                bits    = frame_of(b);
                bits[9] = stop;
                for (i = 0; i < 10; i++)
                begin
                        @(posedge clk);
                        rx <= bits[i];
                        repeat (clks_per_bit - 1) @(posedge clk);
                end
                @(posedge clk);
                rx <= 1'b1;
        endtask

        // samples tx at the bit centres.
        task automatic capture_frame(output logic [9:0] bits);
                int n;
                int i;
                n = 0;
                @(negedge clk);
                while (tx && !aborted && n < wait_limit)
                begin
                        @(negedge clk);
                        n++;
                end
                if (tx)
                        report_timeout("a start bit on tx");
                repeat (clks_per_bit / 2) @(negedge clk);
                bits[0] = tx;
                for (i = 1; i < 10; i++)
                begin
                        repeat (clks_per_bit) @(negedge clk);
                        bits[i] = tx;
                end
        endtask

        initial
        begin : compare_frames
                logic [9:0] got;
                uart_byte_t b;
                int         idle;
                while (!finished && !aborted)
                begin
                        idle = 0;
                        while (exp_q.size() == 0 && !finished && idle < idle_limit)
                        begin
                                @(posedge clk);
                                idle++;
                        end
                        if (idle == idle_limit)
                                report_timeout("the next transmit request");
                        else if (exp_q.size() != 0)
                        begin
                                capture_frame(got);
                                b = exp_q.pop_front();
                                if (got !== frame_of(b))
                                        report_mismatch("tx frame", 32'(frame_of(b)), 32'(got));
                                frames_checked++;
                        end
                end
        end

        initial
        begin
                axil_resp_t resp;
                axil_word_t word;
                uart_byte_t b;
                uart_byte_t b2;
                int         i;
                int         n;
                axi_req <= '0;
                rx      <= 1'b1;
                arst_n  <= 1'b0;
                repeat (8) @(posedge clk);
                arst_n <= 1'b1;

                axil_read(reg_status, word, resp);
                if (word !== 32'h0)
                        report_mismatch("status after reset", 0, word);
                if (resp !== okay)
                        report_mismatch("status response after reset", 32'(okay), 32'(resp));
                if (tx !== 1'b1)
                        report_mismatch("tx after reset", 1, 32'(tx));

                for (i = 0; i < 20; i++)
                begin
                        b = uart_byte_t'($random(seed));
                        exp_q.push_back(b);
                        n = frames_checked;
                        axil_write(reg_txdata, {24'h0, b}, resp);
                        if (resp !== okay)
                                report_mismatch("txdata write response", 32'(okay), 32'(resp));
                        axil_read(reg_status, word, resp);
                        if (word[st_tx_busy] !== 1'b1)
                                report_mismatch("tx_busy during transmit", 1,
                                                32'(word[st_tx_busy]));
                        poll_status(st_tx_busy, 1'b0, word);
                        wait_frames(n + 1);
                end

                // second write lands while the first byte is on the line.
                b  = uart_byte_t'($random(seed));
                b2 = uart_byte_t'($random(seed));
                exp_q.push_back(b);
                n = frames_checked;
                axil_write(reg_txdata, {24'h0, b}, resp);
                if (resp !== okay)
                        report_mismatch("first txdata write response", 32'(okay), 32'(resp));
                axil_write(reg_txdata, {24'h0, b2}, resp);
                if (resp !== slverr)
                        report_mismatch("busy txdata write response", 32'(slverr), 32'(resp));
                wait_frames(n + 1);
                n = 0;
                repeat (12 * clks_per_bit)
                begin
                        @(negedge clk);
                        if (tx !== 1'b1)
                                n++;
                end
                if (n != 0)
                        report_mismatch("low tx samples after refused write", 0, n);
                poll_status(st_tx_busy, 1'b0, word);

                for (i = 0; i < 20; i++)
                begin
                        b = uart_byte_t'($random(seed));
                        send_frame(b, 1'b1);
                        poll_status(st_rx_valid, 1'b1, word);
                        axil_read(reg_rxdata, word, resp);
                        if (word !== {24'h0, b})
                                report_mismatch("rxdata", {24'h0, b}, word);
                        if (resp !== okay)
                                report_mismatch("rxdata response", 32'(okay), 32'(resp));
                        axil_read(reg_status, word, resp);
                        if (word[st_rx_valid] !== 1'b0)
                                report_mismatch("rx_valid after rxdata read", 0,
                                                32'(word[st_rx_valid]));
                end

                b  = uart_byte_t'($random(seed));
                b2 = uart_byte_t'($random(seed));
                send_frame(b, 1'b1);
                send_frame(b2, 1'b1);
                axil_read(reg_status, word, resp);
                if (word !== status_of(1'b1, 1'b0, 1'b1, 1'b0))
                        report_mismatch("status after overrun", status_of(1'b1, 1'b0, 1'b1, 1'b0),
                                        word);
                axil_read(reg_status, word, resp);
                if (word !== status_of(1'b1, 1'b0, 1'b0, 1'b0))
                        report_mismatch("status after overrun cleared",
                                        status_of(1'b1, 1'b0, 1'b0, 1'b0), word);
                axil_read(reg_rxdata, word, resp);
                if (word !== {24'h0, b2})
                        report_mismatch("rxdata after overrun", {24'h0, b2}, word);

                // stop bit driven low.
                b = uart_byte_t'($random(seed));
                send_frame(b, 1'b0);
                axil_read(reg_status, word, resp);
                if (word !== status_of(1'b1, 1'b0, 1'b0, 1'b1))
                        report_mismatch("status after framing error",
                                        status_of(1'b1, 1'b0, 1'b0, 1'b1), word);
                axil_read(reg_status, word, resp);
                if (word !== status_of(1'b1, 1'b0, 1'b0, 1'b0))
                        report_mismatch("status after frame_err cleared",
                                        status_of(1'b1, 1'b0, 1'b0, 1'b0), word);
                axil_read(reg_rxdata, word, resp);
                if (word !== {24'h0, b})
                        report_mismatch("rxdata after framing error", {24'h0, b}, word);
                axil_read(reg_status, word, resp);
                if (word !== 32'h0)
                        report_mismatch("status after last rxdata read", 0, word);

                axil_write(reg_status, 32'h1, resp);
                if (resp !== slverr)
                        report_mismatch("write to status response", 32'(slverr), 32'(resp));
                axil_read(4'hc, word, resp);
                if (resp !== slverr)
                        report_mismatch("read at offset 12 response", 32'(slverr), 32'(resp));
                if (word !== 32'h0)
                        report_mismatch("read at offset 12 data", 0, word);

                finished = 1'b1;
                $display("errors: %0d, timeouts: %0d", errors, timeouts);
                if (errors == 0 && timeouts == 0)
                        $display("Test completed successfully");
                else
                        $display("Test failed");
                $finish;
        end

endmodule

//--- sim.f
common/uart_pkg.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/uart_regs.sv
rtl/uart_top.sv
verification/uart_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the uart testbench with verilator, run it, check for the pass line.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module uart_tb -f sim.f -o uart_sim \
        || { echo "build failed"; exit 1; }
out=$(./obj_dir/uart_sim) || { echo "$out"; echo "simulation did not exit cleanly"; exit 1; }
echo "$out"
echo "$out" | grep -q "Test completed successfully" && exit 0 || exit 1
